// File: hdl/timer_bank_cfg.svh
`ifndef TIMER_BANK_CFG_SVH
`define TIMER_BANK_CFG_SVH

// build-time sizing of the timer bank

// number of timer channels, power of two
`define TB_NUM_TIMERS 4

// counter and compare width
`define TB_CNT_W 32

// bus data width, not narrower than the counter
`define TB_DATA_W 32

// bus address width
// low 2 bits pick the register, upper bits pick the channel
`define TB_ADDR_W 4

`endif

// File: hdl/timer_bank_pkg.sv
`default_nettype none

`include "timer_bank_cfg.svh"

package timer_bank_pkg;

    typedef logic [`TB_DATA_W-1:0] reg_word_t;                 // one bus word
    typedef logic [$clog2(`TB_NUM_TIMERS)-1:0] chan_idx_t;     // channel number
    typedef logic [1:0] reg_sel_t;                             // register select

    // register map inside one channel, select 3 is unmapped
    localparam reg_sel_t REG_TCSR = 2'd0;   // control/status
    localparam reg_sel_t REG_TLR  = 2'd1;   // load/count
    localparam reg_sel_t REG_TCMP = 2'd2;   // compare value

    // control/status layout, bit 0 is enable
    typedef struct packed {
        logic       int_flag;     // bit 6, sticky, write 1 to clear
        logic [2:0] prescale;     // bits 5..3, divide by 2**prescale
        logic       rst_on_cmp;   // bit 2
        logic       int_en;       // bit 1
        logic       enable;       // bit 0
    } tcsr_t;

endpackage

`default_nettype wire

// File: hdl/timer_bank_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "timer_bank_cfg.svh"

module timer_bank_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        bus_stb_i,
    input  logic                        bus_we_i,
    input  logic [`TB_ADDR_W-1:0]       bus_addr_i,
    input  timer_bank_pkg::reg_word_t   bus_dat_i,
    output timer_bank_pkg::reg_word_t   bus_dat_o,
    output logic                        bus_ack_o,
    output logic                        bus_err_o,
    output logic [`TB_NUM_TIMERS-1:0]   irq_o
);
    import timer_bank_pkg::*;

    logic [`TB_NUM_TIMERS-1:0]  wr_stb;
    logic [`TB_NUM_TIMERS-1:0]  rd_stb;
    reg_sel_t                   reg_sel;
    reg_word_t                  wr_data;
    chan_idx_t                  rd_chan;
    reg_word_t                  rd_data [`TB_NUM_TIMERS];
    logic [`TB_NUM_TIMERS-1:0]  chan_irq;

    timer_bus_decode u_decode (
        .clk        (clk),
        .reset      (reset),
        .bus_stb_i  (bus_stb_i),
        .bus_we_i   (bus_we_i),
        .bus_addr_i (bus_addr_i),
        .bus_dat_i  (bus_dat_i),
        .wr_stb_o   (wr_stb),
        .rd_stb_o   (rd_stb),
        .reg_sel_o  (reg_sel),
        .wr_data_o  (wr_data),
        .rd_chan_o  (rd_chan),
        .bus_ack_o  (bus_ack_o),
        .bus_err_o  (bus_err_o)
    );

    for (genvar i = 0; i < `TB_NUM_TIMERS; i++) begin : g_chan
        timer_channel u_chan (
            .clk        (clk),
            .reset      (reset),
            .wr_stb_i   (wr_stb[i]),
            .rd_stb_i   (rd_stb[i]),
            .reg_sel_i  (reg_sel),   // select and data are shared by all channels
            .wr_data_i  (wr_data),
            .rd_data_o  (rd_data[i]),
            .irq_o      (chan_irq[i])
        );
    end

    timer_read_gather u_gather (
        .clk        (clk),
        .reset      (reset),
        .rd_data_i  (rd_data),
        .irq_i      (chan_irq),
        .rd_chan_i  (rd_chan),
        .bus_ack_i  (bus_ack_o),
        .bus_dat_o  (bus_dat_o),
        .irq_o      (irq_o)
    );

endmodule

`default_nettype wire

// File: hdl/timer_bus_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "timer_bank_cfg.svh"

module timer_bus_decode (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            bus_stb_i,
    input  logic                            bus_we_i,
    input  logic [`TB_ADDR_W-1:0]           bus_addr_i,
    input  timer_bank_pkg::reg_word_t       bus_dat_i,
    output logic [`TB_NUM_TIMERS-1:0]       wr_stb_o,
    output logic [`TB_NUM_TIMERS-1:0]       rd_stb_o,
    output timer_bank_pkg::reg_sel_t        reg_sel_o,
    output timer_bank_pkg::reg_word_t       wr_data_o,
    output timer_bank_pkg::chan_idx_t       rd_chan_o,
    output logic                            bus_ack_o,
    output logic                            bus_err_o
);
    import timer_bank_pkg::*;

    localparam int CHAN_FW = `TB_ADDR_W - 2;   // width of the channel field

    logic [CHAN_FW-1:0]         chan_field;
    reg_sel_t                   sel;
    logic                       accept;
    logic                       reg_ok;
    logic                       chan_ok;
    logic                       hit;
    logic [`TB_NUM_TIMERS-1:0]  chan_onehot;

    assign sel        = bus_addr_i[1:0];
    assign chan_field = bus_addr_i[`TB_ADDR_W-1:2];

    // new access only if we did not answer last cycle
    assign accept  = bus_stb_i && !(bus_ack_o || bus_err_o);
    assign reg_ok  = (sel == REG_TCSR) || (sel == REG_TLR) || (sel == REG_TCMP);
    assign chan_ok = int'(chan_field) < `TB_NUM_TIMERS;   // guards oversized address maps
    assign hit     = accept && reg_ok && chan_ok;

    always_comb begin
        chan_onehot = '0;
        for (int i = 0; i < `TB_NUM_TIMERS; i++) begin
            if (int'(chan_field) == i) begin
                chan_onehot[i] = 1'b1;
            end
        end
    end

    // strobes are combinational, channels act on the sampling edge
    assign wr_stb_o  = (hit && bus_we_i)  ? chan_onehot : '0;
    assign rd_stb_o  = (hit && !bus_we_i) ? chan_onehot : '0;
    assign reg_sel_o = sel;
    assign wr_data_o = bus_dat_i;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bus_ack_o <= 1'b0;
            bus_err_o <= 1'b0;
            rd_chan_o <= '0;
        end else begin
            bus_ack_o <= hit;
            bus_err_o <= accept && !(reg_ok && chan_ok);   // unmapped register or channel
            if (hit) begin
                rd_chan_o <= chan_idx_t'(chan_field);   // held through the answer cycle
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/timer_channel.sv
`timescale 1ns/100ps
`default_nettype none

`include "timer_bank_cfg.svh"

module timer_channel (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        wr_stb_i,
    input  logic                        rd_stb_i,
    input  timer_bank_pkg::reg_sel_t    reg_sel_i,
    input  timer_bank_pkg::reg_word_t   wr_data_i,
    output timer_bank_pkg::reg_word_t   rd_data_o,
    output logic                        irq_o
);
    import timer_bank_pkg::*;

    localparam int PRE_W = 7;   // enough for 2**7 - 1

    tcsr_t                  ctrl;
    tcsr_t                  ctrl_wr;
    logic [`TB_CNT_W-1:0]   count;
    logic [`TB_CNT_W-1:0]   compare;
    logic [PRE_W-1:0]       pre_cnt;
    logic [PRE_W-1:0]       pre_max;
    logic                   tcsr_wr;
    logic                   tlr_wr;
    logic                   tcmp_wr;
    logic                   tick;
    logic                   cmp_hit;
    logic                   flag_set;
    logic                   int_en_next;

    assign tcsr_wr = wr_stb_i && (reg_sel_i == REG_TCSR);
    assign tlr_wr  = wr_stb_i && (reg_sel_i == REG_TLR);
    assign tcmp_wr = wr_stb_i && (reg_sel_i == REG_TCMP);
    assign ctrl_wr = tcsr_t'(wr_data_i[$bits(tcsr_t)-1:0]);

    // terminal count is 2**prescale - 1
    assign pre_max = ~({PRE_W{1'b1}} << ctrl.prescale);
    assign tick    = ctrl.enable && (pre_cnt >= pre_max);   // >= covers a prescale drop

    assign cmp_hit     = ctrl.rst_on_cmp && (count == compare);
    assign flag_set    = tick && cmp_hit && ctrl.int_en;
    assign int_en_next = tcsr_wr ? ctrl_wr.int_en : ctrl.int_en;

    // prescaler
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pre_cnt <= '0;
        end else if (!ctrl.enable || tick) begin
            pre_cnt <= '0;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    // counter, a load wins over counting
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (tlr_wr) begin
            count <= wr_data_i[`TB_CNT_W-1:0];
        end else if (tick) begin
            if (cmp_hit) begin
                count <= '0;   // wrap on compare
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            compare <= '1;
        end else if (tcmp_wr) begin
            compare <= wr_data_i[`TB_CNT_W-1:0];
        end
    end

    // control fields and the sticky flag
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctrl <= '0;
        end else begin
            if (tcsr_wr) begin
                ctrl.enable     <= ctrl_wr.enable;
                ctrl.int_en     <= ctrl_wr.int_en;
                ctrl.rst_on_cmp <= ctrl_wr.rst_on_cmp;
                ctrl.prescale   <= ctrl_wr.prescale;
            end
            if (tcsr_wr && ctrl_wr.int_flag) begin
                ctrl.int_flag <= 1'b0;   // write 1 clears, beats a new hit
            end else begin
                ctrl.int_flag <= (ctrl.int_flag || flag_set) && int_en_next;
            end
        end
    end

    // read word is captured on the sampling edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_data_o <= '0;
        end else if (rd_stb_i) begin
            case (reg_sel_i)
                REG_TCSR: rd_data_o <= reg_word_t'(ctrl);
                REG_TLR:  rd_data_o <= reg_word_t'(count);
                REG_TCMP: rd_data_o <= reg_word_t'(compare);
                default:  rd_data_o <= rd_data_o;   // decoder never strobes select 3
            endcase
        end
    end

    assign irq_o = ctrl.int_flag;

endmodule

`default_nettype wire

// File: hdl/timer_read_gather.sv
`timescale 1ns/100ps
`default_nettype none

`include "timer_bank_cfg.svh"

module timer_read_gather (
    input  logic                        clk,
    input  logic                        reset,
    input  timer_bank_pkg::reg_word_t   rd_data_i [`TB_NUM_TIMERS],
    input  logic [`TB_NUM_TIMERS-1:0]   irq_i,
    input  timer_bank_pkg::chan_idx_t   rd_chan_i,
    input  logic                        bus_ack_i,
    output timer_bank_pkg::reg_word_t   bus_dat_o,
    output logic [`TB_NUM_TIMERS-1:0]   irq_o
);
    import timer_bank_pkg::*;

    reg_word_t  sel_word;

    // channel words are already registered, so the mux stays combinational
    // and the data lines up with ack
    assign sel_word  = rd_data_i[rd_chan_i];
    assign bus_dat_o = bus_ack_i ? sel_word : '0;   // quiet bus outside the answer

    // one flop per interrupt line, so the port never glitches
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            irq_o <= '0;
        end else begin
            irq_o <= irq_i;
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the timer bank testbench with Verilator.
# The run passes only if the simulation output holds the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f timer_bank.f \
    --top-module timer_bank_tb \
    -Mdir obj_dir \
    -o timer_bank_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/timer_bank_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ "$sim_status" -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'PASS: all tests'; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: tb/timer_bank_assertions.sv
`timescale 1ns/100ps
`default_nettype none

`include "timer_bank_cfg.svh"

module timer_bank_assertions (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        bus_ack_i,
    input  logic                        bus_err_i,
    input  logic [`TB_NUM_TIMERS-1:0]   irq_i
);

    // failure counts per property
    int ack_err_fails = 0;
    int ack_len_fails = 0;
    int err_len_fails = 0;
    int irq_rst_fails = 0;

    // one answer per access, never both kinds
    a_ack_err_excl: assert property (@(posedge clk) disable iff (reset)
        !(bus_ack_i && bus_err_i))
        else begin
            ack_err_fails++;
            $error("ack and err are high in the same cycle");
        end

    a_ack_single: assert property (@(posedge clk) disable iff (reset)
        bus_ack_i |=> !bus_ack_i)
        else begin
            ack_len_fails++;
            $error("ack stayed high for two cycles");
        end

    a_err_single: assert property (@(posedge clk) disable iff (reset)
        bus_err_i |=> !bus_err_i)
        else begin
            err_len_fails++;
            $error("err stayed high for two cycles");
        end

    a_irq_reset: assert property (@(posedge clk) reset |-> (irq_i == '0))
        else begin
            irq_rst_fails++;
            $error("irq_o is not zero during reset");
        end

endmodule

bind timer_bank_top timer_bank_assertions u_assert (
    .clk        (clk),
    .reset      (reset),
    .bus_ack_i  (bus_ack_o),
    .bus_err_i  (bus_err_o),
    .irq_i      (irq_o)
);

`default_nettype wire

// File: tb/timer_bank_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "timer_bank_cfg.svh"

module timer_bank_tb;
    import timer_bank_pkg::*;

    typedef logic [`TB_NUM_TIMERS-1:0] irq_vec_t;

    localparam int ACK_TIMEOUT = 16;    // cycles from stb to ack or err
    localparam int IRQ_TIMEOUT = 400;   // cycles for an irq level change

    logic                   clk;
    logic                   reset;
    logic                   bus_stb_i;
    logic                   bus_we_i;
    logic [`TB_ADDR_W-1:0]  bus_addr_i;
    reg_word_t              bus_dat_i;
    reg_word_t              bus_dat_o;
    logic                   bus_ack_o;
    logic                   bus_err_o;
    irq_vec_t               irq_o;

    reg_word_t              last_count;   // previous counter read of a pair

    timer_bank_top u_dut (
        .clk        (clk),
        .reset      (reset),
        .bus_stb_i  (bus_stb_i),
        .bus_we_i   (bus_we_i),
        .bus_addr_i (bus_addr_i),
        .bus_dat_i  (bus_dat_i),
        .bus_dat_o  (bus_dat_o),
        .bus_ack_o  (bus_ack_o),
        .bus_err_o  (bus_err_o),
        .irq_o      (irq_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_word(string name, reg_word_t expected, reg_word_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("MISMATCH %s: expected %h, actual %h",
                                     name, expected, actual));
        end
    endtask

    task automatic check_irq(string name, irq_vec_t expected, irq_vec_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("MISMATCH %s: expected irq %b, actual irq %b",
                                     name, expected, actual));
        end
    endtask

    // running counter, may have advanced once but never backwards
    task automatic check_count(string name, reg_word_t base, reg_word_t prev,
                               reg_word_t actual);
        if (actual < base || actual > base + 32'd1 || actual < prev) begin
            report_failure($sformatf("MISMATCH %s: expected %h or %h not below %h, actual %h",
                                     name, base, base + 32'd1, prev, actual));
        end
    endtask

    // one bus access, inputs change 2 ns after the edge
    task automatic bus_access(
        input  logic        we,
        input  int          chan,
        input  int          sel,
        input  reg_word_t   wdata,
        output reg_word_t   rdata,
        output logic        got_ack,
        output logic        got_err
    );
        int waited;
        waited  = 0;
        got_ack = 1'b0;
        got_err = 1'b0;
        rdata   = '0;
        @(posedge clk);
        #2;
        bus_stb_i  = 1'b1;
        bus_we_i   = we;
        bus_addr_i = {chan_idx_t'(chan), reg_sel_t'(sel)};
        bus_dat_i  = wdata;
        while (!got_ack && !got_err) begin
            @(posedge clk);
            #2;
            got_ack = bus_ack_o;   // stable until the next edge
            got_err = bus_err_o;
            rdata   = bus_dat_o;
            waited++;
            if (!got_ack && !got_err && waited >= ACK_TIMEOUT) begin
                report_failure($sformatf("no ack or err within %0d cycles for channel %0d register %0d",
                                         ACK_TIMEOUT, chan, sel));
            end
        end
        bus_stb_i = 1'b0;
        bus_we_i  = 1'b0;
    endtask

    task automatic wait_irq(string name, int chan, logic level);
        int waited;
        waited = 0;
        while (irq_o[chan] !== level) begin
            @(posedge clk);
            #2;
            waited++;
            if (irq_o[chan] !== level && waited >= IRQ_TIMEOUT) begin
                report_failure($sformatf("%s: irq bit %0d did not reach %0b within %0d cycles",
                                         name, chan, level, IRQ_TIMEOUT));
            end
        end
    endtask

    task automatic run_line(string name, logic [7:0] op, int chan, int sel,
                            reg_word_t wdata, reg_word_t expv);
        reg_word_t  rdata;
        logic       got_ack;
        logic       got_err;
        if (op != "C") begin
            last_count = '0;
        end
        case (op)
            "W", "R", "C": begin
                bus_access(op == "W", chan, sel, wdata, rdata, got_ack, got_err);
                if (got_err) begin
                    report_failure($sformatf("%s: access answered with err instead of ack",
                                             name));
                end
                if (op == "R") begin
                    check_word(name, expv, rdata);
                end else if (op == "C") begin
                    check_count(name, expv, last_count, rdata);
                    last_count = rdata;
                end
            end
            "E": begin
                bus_access(1'b1, chan, sel, wdata, rdata, got_ack, got_err);
                if (got_ack) begin
                    report_failure($sformatf("%s: unmapped access answered with ack", name));
                end
            end
            "I": begin
                wait_irq(name, chan, wdata[0]);
                check_irq(name, expv[`TB_NUM_TIMERS-1:0], irq_o);
            end
            default: begin
                report_failure($sformatf("%s: unknown operation %s in test file", name, op));
            end
        endcase
    endtask

    // a failed bound assertion ends the run at the next falling edge
    always @(negedge clk) begin
        if (u_dut.u_assert.ack_err_fails + u_dut.u_assert.ack_len_fails
                + u_dut.u_assert.err_len_fails + u_dut.u_assert.irq_rst_fails != 0) begin
            report_failure("a bound assertion failed on the bus or interrupt port");
        end
    end

    initial begin
        int                 fd;
        int                 fields;
        int                 chan;
        int                 sel;
        int                 assert_fails;
        string              line;
        string              name;
        logic [8*24-1:0]    name_buf;
        logic [8*4-1:0]     op_buf;
        reg_word_t          wdata;
        reg_word_t          expv;
        reset      = 1'b1;
        bus_stb_i  = 1'b0;
        bus_we_i   = 1'b0;
        bus_addr_i = '0;
        bus_dat_i  = '0;
        last_count = '0;
        fd = $fopen("tb/timer_bank_tests.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open test file tb/timer_bank_tests.txt");
        end
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;   // comment or blank line
            end
            fields = $sscanf(line, "%s %s %d %d %h %h", name_buf, op_buf, chan, sel,
                             wdata, expv);
            if (fields != 6) begin
                report_failure($sformatf("malformed test line: %s", line));
            end
            name = $sformatf("%0s", name_buf);
            run_line(name, op_buf[7:0], chan, sel, wdata, expv);
        end
        $fclose(fd);
        assert_fails = u_dut.u_assert.ack_err_fails + u_dut.u_assert.ack_len_fails
                     + u_dut.u_assert.err_len_fails + u_dut.u_assert.irq_rst_fails;
        if (assert_fails == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            report_failure($sformatf("%0d assertion failures during the run", assert_fails));
        end
    end

endmodule

`default_nettype wire

// File: tb/timer_bank_tests.txt
# name op chan reg wdata(hex) expect(hex)
# op W write, R read exact, C counter read in expect..expect+1, E unmapped write, I irq wait
rst_tcsr0 R 0 0 00000000 00000000
rst_tcmp0 R 0 2 00000000 ffffffff
rst_tcsr1 R 1 0 00000000 00000000
rst_tcmp1 R 1 2 00000000 ffffffff
rst_tcsr2 R 2 0 00000000 00000000
rst_tcmp2 R 2 2 00000000 ffffffff
rst_tcsr3 R 3 0 00000000 00000000
rst_tcmp3 R 3 2 00000000 ffffffff
tcmp2_wr W 2 2 1234abcd 00000000
tcmp2_rd R 2 2 00000000 1234abcd
tlr0_wr W 0 1 00000011 00000000
tlr1_wr W 1 1 00002222 00000000
tlr2_wr W 2 1 00330000 00000000
tlr3_wr W 3 1 44000000 00000000
tlr0_rd R 0 1 00000000 00000011
tlr1_rd R 1 1 00000000 00002222
tlr2_rd R 2 1 00000000 00330000
tlr3_rd R 3 1 00000000 44000000
bad_sel E 3 3 deadbeef 00000000
bad_tlr3 R 3 1 00000000 44000000
bad_tcsr3 R 3 0 00000000 00000000
cnt_load W 0 1 00000100 00000000
cnt_en W 0 0 00000039 00000000
cnt_rd1 C 0 1 00000000 00000100
cnt_rd2 C 0 1 00000000 00000100
irq_cmp W 1 2 00000005 00000000
irq_load W 1 1 00000000 00000000
irq_en W 1 0 00000007 00000000
irq_rise I 1 0 00000001 00000002
irq_tcsr R 1 0 00000000 00000047
clr_cmp W 1 2 ffffffff 00000000
clr_wr W 1 0 00000047 00000000
clr_fall I 1 0 00000000 00000000
clr_tcsr R 1 0 00000000 00000007

// File: timer_bank.f
+incdir+hdl
hdl/timer_bank_pkg.sv
hdl/timer_bus_decode.sv
hdl/timer_channel.sv
hdl/timer_read_gather.sv
hdl/timer_bank_top.sv
tb/timer_bank_assertions.sv
tb/timer_bank_tb.sv
